/* rtl/frontend_pkg.sv */
package frontend_pkg;

  // instruction class produced by predecode and carried through the queue.
  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_store,
    op_branch,
    op_illegal
  } op_e;

  // major opcode values found in instruction bits 6 down to 0.
  localparam logic [6:0] opc_alu_reg = 7'b0110011;
  localparam logic [6:0] opc_alu_imm = 7'b0010011;
  localparam logic [6:0] opc_load    = 7'b0000011;
  localparam logic [6:0] opc_store   = 7'b0100011;

  // conditional branches and unconditional jumps share one class.
  localparam logic [6:0] opc_branch  = 7'b1100011;
  localparam logic [6:0] opc_jump    = 7'b1101111;

endpackage

/* rtl/predecode_stage.sv */
`timescale 1ns/1ps

module predecode_stage import frontend_pkg::*; #(
  parameter int INSTR_WIDTH = 32,
  parameter int PC_WIDTH = 32,
  parameter int ADDR_WIDTH = 4
) (
  input  logic clk,
  input  logic reset,

  input  logic fetch_valid0,
  input  logic fetch_valid1,
  input  logic [PC_WIDTH-1:0] fetch_pc,
  input  logic [INSTR_WIDTH-1:0] fetch_instr0,
  input  logic [INSTR_WIDTH-1:0] fetch_instr1,
  output logic fetch_ready,

  input  logic [ADDR_WIDTH:0] free_slots,

  output logic push0,
  output logic push1,
  output logic [PC_WIDTH-1:0] push_pc0,
  output logic [PC_WIDTH-1:0] push_pc1,
  output logic [INSTR_WIDTH-1:0] push_instr0,
  output logic [INSTR_WIDTH-1:0] push_instr1,
  output op_e push_op0,
  output op_e push_op1
);

  logic accept;

  function automatic op_e classify(input logic [6:0] opc);
    case (opc)
      opc_alu_reg, opc_alu_imm: classify = op_alu;
      opc_load:                 classify = op_load;
      opc_store:                classify = op_store;
      opc_branch, opc_jump:     classify = op_branch;
      default:                  classify = op_illegal;
    endcase
  endfunction

  // room for the pair held here and one more pair behind it.
  assign fetch_ready = (free_slots >= 4);
  assign accept = fetch_ready && fetch_valid0;

  always_ff @(posedge clk) begin
    if (reset) begin
      push0 <= 1'b0;
      push1 <= 1'b0;
    end else begin
      push0 <= accept;
      push1 <= accept && fetch_valid1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      push_pc0 <= fetch_pc;
      push_pc1 <= fetch_pc + PC_WIDTH'(4);
      push_instr0 <= fetch_instr0;
      push_instr1 <= fetch_instr1;
      push_op0 <= classify(fetch_instr0[6:0]);
      push_op1 <= classify(fetch_instr1[6:0]);
    end
  end

  // the second fetch slot is only meaningful behind the first.
  a_fetch_order: assert property (@(posedge clk) disable iff (reset)
    fetch_valid1 |-> fetch_valid0);

endmodule

/* rtl/dual_issue_queue.sv */
`timescale 1ns/1ps

module dual_issue_queue import frontend_pkg::*; #(
  parameter int INSTR_WIDTH = 32,
  parameter int PC_WIDTH = 32,
  parameter int ADDR_WIDTH = 4
) (
  input  logic clk,
  input  logic reset,

  input  logic push0,
  input  logic push1,
  input  logic [PC_WIDTH-1:0] push_pc0,
  input  logic [PC_WIDTH-1:0] push_pc1,
  input  logic [INSTR_WIDTH-1:0] push_instr0,
  input  logic [INSTR_WIDTH-1:0] push_instr1,
  input  op_e push_op0,
  input  op_e push_op1,

  input  logic pop0,
  input  logic pop1,

  output logic [ADDR_WIDTH:0] count,
  output logic [ADDR_WIDTH:0] free_slots,
  output logic [PC_WIDTH-1:0] head_pc0,
  output logic [PC_WIDTH-1:0] head_pc1,
  output logic [INSTR_WIDTH-1:0] head_instr0,
  output logic [INSTR_WIDTH-1:0] head_instr1,
  output op_e head_op0,
  output op_e head_op1
);

  localparam int DEPTH = 1 << ADDR_WIDTH;
  localparam logic [ADDR_WIDTH:0] CAPACITY = (ADDR_WIDTH+1)'(DEPTH - 1);

  logic [PC_WIDTH-1:0] pc_mem [DEPTH];
  logic [INSTR_WIDTH-1:0] instr_mem [DEPTH];
  op_e op_mem [DEPTH];

  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] wr_ptr_p1;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr_p1;

  logic write0;
  logic write1;
  logic read0;
  logic read1;
  logic [1:0] n_push;
  logic [1:0] n_pop;

  // slot 1 is only written or read alongside slot 0.
  assign write0 = push0;
  assign write1 = push0 && push1;
  assign read0 = pop0;
  assign read1 = pop0 && pop1;

  assign n_push = {1'b0, write0} + {1'b0, write1};
  assign n_pop = {1'b0, read0} + {1'b0, read1};

  assign wr_ptr_p1 = wr_ptr + ADDR_WIDTH'(1);
  assign rd_ptr_p1 = rd_ptr + ADDR_WIDTH'(1);

  assign free_slots = CAPACITY - count;

  assign head_pc0 = pc_mem[rd_ptr];
  assign head_pc1 = pc_mem[rd_ptr_p1];
  assign head_instr0 = instr_mem[rd_ptr];
  assign head_instr1 = instr_mem[rd_ptr_p1];
  assign head_op0 = op_mem[rd_ptr];
  assign head_op1 = op_mem[rd_ptr_p1];

  always_ff @(posedge clk) begin
    if (write0) begin
      pc_mem[wr_ptr] <= push_pc0;
      instr_mem[wr_ptr] <= push_instr0;
      op_mem[wr_ptr] <= push_op0;
    end
    if (write1) begin
      pc_mem[wr_ptr_p1] <= push_pc1;
      instr_mem[wr_ptr_p1] <= push_instr1;
      op_mem[wr_ptr_p1] <= push_op1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      wr_ptr <= wr_ptr + ADDR_WIDTH'(n_push);
      rd_ptr <= rd_ptr + ADDR_WIDTH'(n_pop);
      count <= count + (ADDR_WIDTH+1)'(n_push) - (ADDR_WIDTH+1)'(n_pop);
    end
  end

  // the predecode ready rule keeps pushes within the free space.
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    int'(n_push) <= int'(free_slots));

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    int'(n_pop) <= int'(count));

  a_pop_order: assert property (@(posedge clk) disable iff (reset)
    pop1 |-> pop0);

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage import frontend_pkg::*; #(
  parameter int INSTR_WIDTH = 32,
  parameter int PC_WIDTH = 32,
  parameter int ADDR_WIDTH = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic issue_stall,

  input  logic [ADDR_WIDTH:0] count,
  input  logic [PC_WIDTH-1:0] head_pc0,
  input  logic [PC_WIDTH-1:0] head_pc1,
  input  logic [INSTR_WIDTH-1:0] head_instr0,
  input  logic [INSTR_WIDTH-1:0] head_instr1,
  input  op_e head_op0,
  input  op_e head_op1,

  output logic pop0,
  output logic pop1,

  output logic issue_valid0,
  output logic issue_valid1,
  output logic [PC_WIDTH-1:0] issue_pc0,
  output logic [PC_WIDTH-1:0] issue_pc1,
  output logic [INSTR_WIDTH-1:0] issue_instr0,
  output logic [INSTR_WIDTH-1:0] issue_instr1,
  output op_e issue_op0,
  output op_e issue_op1
);

  // two branches or two memory operations cannot share an issue cycle.
  function automatic logic is_conflict(input op_e a, input op_e b);
    logic a_mem;
    logic b_mem;
    a_mem = (a == op_load) || (a == op_store);
    b_mem = (b == op_load) || (b == op_store);
    return ((a == op_branch) && (b == op_branch)) || (a_mem && b_mem);
  endfunction

  assign pop0 = !issue_stall && (count != '0);
  assign pop1 = pop0 && (count >= 2) && !is_conflict(head_op0, head_op1);

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_valid0 <= 1'b0;
      issue_valid1 <= 1'b0;
    end else begin
      issue_valid0 <= pop0;
      issue_valid1 <= pop1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop0) begin
      issue_pc0 <= head_pc0;
      issue_instr0 <= head_instr0;
      issue_op0 <= head_op0;
    end
    if (pop1) begin
      issue_pc1 <= head_pc1;
      issue_instr1 <= head_instr1;
      issue_op1 <= head_op1;
    end
  end

  // an issued pair never holds two branches or two memory operations.
  a_legal_pair: assert property (@(posedge clk) disable iff (reset)
    issue_valid1 |-> !is_conflict(issue_op0, issue_op1));

endmodule

/* rtl/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top import frontend_pkg::*; #(
  parameter int INSTR_WIDTH = 32,
  parameter int PC_WIDTH = 32,
  parameter int ADDR_WIDTH = 4
) (
  input  logic clk,
  input  logic reset,

  input  logic fetch_valid0,
  input  logic fetch_valid1,
  input  logic [PC_WIDTH-1:0] fetch_pc,
  input  logic [INSTR_WIDTH-1:0] fetch_instr0,
  input  logic [INSTR_WIDTH-1:0] fetch_instr1,
  output logic fetch_ready,

  input  logic issue_stall,
  output logic issue_valid0,
  output logic issue_valid1,
  output logic [PC_WIDTH-1:0] issue_pc0,
  output logic [PC_WIDTH-1:0] issue_pc1,
  output logic [INSTR_WIDTH-1:0] issue_instr0,
  output logic [INSTR_WIDTH-1:0] issue_instr1,
  output op_e issue_op0,
  output op_e issue_op1
);

  logic push0;
  logic push1;
  logic [PC_WIDTH-1:0] push_pc0;
  logic [PC_WIDTH-1:0] push_pc1;
  logic [INSTR_WIDTH-1:0] push_instr0;
  logic [INSTR_WIDTH-1:0] push_instr1;
  op_e push_op0;
  op_e push_op1;

  logic pop0;
  logic pop1;
  logic [ADDR_WIDTH:0] count;
  logic [ADDR_WIDTH:0] free_slots;
  logic [PC_WIDTH-1:0] head_pc0;
  logic [PC_WIDTH-1:0] head_pc1;
  logic [INSTR_WIDTH-1:0] head_instr0;
  logic [INSTR_WIDTH-1:0] head_instr1;
  op_e head_op0;
  op_e head_op1;

  predecode_stage #(
    .INSTR_WIDTH(INSTR_WIDTH),
    .PC_WIDTH(PC_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_predecode (
    .clk(clk),
    .reset(reset),
    .fetch_valid0(fetch_valid0),
    .fetch_valid1(fetch_valid1),
    .fetch_pc(fetch_pc),
    .fetch_instr0(fetch_instr0),
    .fetch_instr1(fetch_instr1),
    .fetch_ready(fetch_ready),
    .free_slots(free_slots),
    .push0(push0),
    .push1(push1),
    .push_pc0(push_pc0),
    .push_pc1(push_pc1),
    .push_instr0(push_instr0),
    .push_instr1(push_instr1),
    .push_op0(push_op0),
    .push_op1(push_op1)
  );

  dual_issue_queue #(
    .INSTR_WIDTH(INSTR_WIDTH),
    .PC_WIDTH(PC_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_queue (
    .clk(clk),
    .reset(reset),
    .push0(push0),
    .push1(push1),
    .push_pc0(push_pc0),
    .push_pc1(push_pc1),
    .push_instr0(push_instr0),
    .push_instr1(push_instr1),
    .push_op0(push_op0),
    .push_op1(push_op1),
    .pop0(pop0),
    .pop1(pop1),
    .count(count),
    .free_slots(free_slots),
    .head_pc0(head_pc0),
    .head_pc1(head_pc1),
    .head_instr0(head_instr0),
    .head_instr1(head_instr1),
    .head_op0(head_op0),
    .head_op1(head_op1)
  );

  issue_stage #(
    .INSTR_WIDTH(INSTR_WIDTH),
    .PC_WIDTH(PC_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) u_issue (
    .clk(clk),
    .reset(reset),
    .issue_stall(issue_stall),
    .count(count),
    .head_pc0(head_pc0),
    .head_pc1(head_pc1),
    .head_instr0(head_instr0),
    .head_instr1(head_instr1),
    .head_op0(head_op0),
    .head_op1(head_op1),
    .pop0(pop0),
    .pop1(pop1),
    .issue_valid0(issue_valid0),
    .issue_valid1(issue_valid1),
    .issue_pc0(issue_pc0),
    .issue_pc1(issue_pc1),
    .issue_instr0(issue_instr0),
    .issue_instr1(issue_instr1),
    .issue_op0(issue_op0),
    .issue_op1(issue_op1)
  );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 2
) (
  output logic clk
);

  initial clk = 1'b0;

  // two half periods of 2 ns give the 4 ns clock.
  always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

/* sim/tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend import frontend_pkg::*; ();

  localparam int INSTR_WIDTH = 32;
  localparam int PC_WIDTH = 32;
  localparam int ADDR_WIDTH = 4;
  localparam int WAIT_LIMIT = 400;

  logic clk;
  logic reset;
  logic fetch_valid0;
  logic fetch_valid1;
  logic [PC_WIDTH-1:0] fetch_pc;
  logic [INSTR_WIDTH-1:0] fetch_instr0;
  logic [INSTR_WIDTH-1:0] fetch_instr1;
  logic fetch_ready;
  logic issue_stall;
  logic issue_valid0;
  logic issue_valid1;
  logic [PC_WIDTH-1:0] issue_pc0;
  logic [PC_WIDTH-1:0] issue_pc1;
  logic [INSTR_WIDTH-1:0] issue_instr0;
  logic [INSTR_WIDTH-1:0] issue_instr1;
  op_e issue_op0;
  op_e issue_op1;

  int seed = 89627;
  int cyc = 0;
  logic reset_seen = 1'b0;
  int mismatch_count = 0;
  int failure_count = 0;
  int words_issued = 0;
  logic [PC_WIDTH-1:0] next_pc;
  bit ready_low_seen;

  // words accepted by the front end, oldest first, with their acceptance cycle.
  logic [INSTR_WIDTH-1:0] q_instr [$];
  logic [PC_WIDTH-1:0] q_pc [$];
  int q_stamp [$];
  bit q_probe [$];

  logic [INSTR_WIDTH-1:0] exp_instr0;
  logic [INSTR_WIDTH-1:0] exp_instr1;
  logic [PC_WIDTH-1:0] exp_pc0;
  logic [PC_WIDTH-1:0] exp_pc1;
  op_e exp_op0;
  op_e exp_op1;
  bit pair_ok = 1'b0;
  bit underrun = 1'b0;
  bit probe_hit = 1'b0;
  int probe_lat = 0;

  tb_clock_gen i_clock (
    .clk(clk)
  );

  frontend_top #(
    .INSTR_WIDTH(INSTR_WIDTH),
    .PC_WIDTH(PC_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) i_dut (
    .clk(clk),
    .reset(reset),
    .fetch_valid0(fetch_valid0),
    .fetch_valid1(fetch_valid1),
    .fetch_pc(fetch_pc),
    .fetch_instr0(fetch_instr0),
    .fetch_instr1(fetch_instr1),
    .fetch_ready(fetch_ready),
    .issue_stall(issue_stall),
    .issue_valid0(issue_valid0),
    .issue_valid1(issue_valid1),
    .issue_pc0(issue_pc0),
    .issue_pc1(issue_pc1),
    .issue_instr0(issue_instr0),
    .issue_instr1(issue_instr1),
    .issue_op0(issue_op0),
    .issue_op1(issue_op1)
  );

  function automatic op_e class_of(input logic [INSTR_WIDTH-1:0] word);
    case (word[6:0])
      opc_alu_reg, opc_alu_imm: return op_alu;
      opc_load:                 return op_load;
      opc_store:                return op_store;
      opc_branch, opc_jump:     return op_branch;
      default:                  return op_illegal;
    endcase
  endfunction

  function automatic bit is_mem(input op_e op);
    return (op == op_load) || (op == op_store);
  endfunction

  function automatic bit pair_blocked(input op_e a, input op_e b);
    return ((a == op_branch) && (b == op_branch)) || (is_mem(a) && is_mem(b));
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[30:0]) % n;
  endfunction

  // the last three choices are opcodes the front end does not know.
  function automatic logic [INSTR_WIDTH-1:0] rand_word();
    logic [31:0] r;
    logic [6:0] opc;
    r = $random(seed);
    case (rand_below(9))
      0: opc = opc_alu_reg;
      1: opc = opc_alu_imm;
      2: opc = opc_load;
      3: opc = opc_store;
      4: opc = opc_branch;
      5: opc = opc_jump;
      6: opc = 7'h00;
      7: opc = 7'h7f;
      default: opc = 7'h17;
    endcase
    return {r[31:7], opc};
  endfunction

  function automatic void count_mismatch(input string test, input logic [31:0] expected,
                                         input logic [31:0] actual);
    mismatch_count++;
    $display("Mismatch %s: expected %h actual %h", test, expected, actual);
  endfunction

  function automatic void log_failure(input string what);
    failure_count++;
    $display("error: %s", what);
  endfunction

  function automatic void record_word(input logic [INSTR_WIDTH-1:0] word,
                                      input logic [PC_WIDTH-1:0] pc, input bit probe);
    q_instr.push_back(word);
    q_pc.push_back(pc);
    q_stamp.push_back(cyc + 1);
    q_probe.push_back(probe);
  endfunction

  function automatic void take_oldest(input int slot);
    logic [INSTR_WIDTH-1:0] w;
    logic [PC_WIDTH-1:0] a;
    int stamp;
    if (q_instr.size() == 0) begin
      underrun = 1'b1;
      return;
    end
    w = q_instr.pop_front();
    a = q_pc.pop_front();
    stamp = q_stamp.pop_front();
    // latency counts the acceptance edge itself as the first clock.
    if (q_probe.pop_front()) begin
      probe_hit = 1'b1;
      probe_lat = cyc - stamp + 1;
    end
    words_issued++;
    if (slot == 0) begin
      exp_instr0 = w;
      exp_pc0 = a;
      exp_op0 = class_of(w);
    end else begin
      exp_instr1 = w;
      exp_pc1 = a;
      exp_op1 = class_of(w);
    end
  endfunction

  always @(posedge clk) begin
    cyc <= cyc + 1;
    reset_seen <= reset;
  end

  // outputs are stable at the falling edge, so the reference model updates here.
  always @(negedge clk) begin : model_update
    int waiting;
    probe_hit = 1'b0;
    underrun = 1'b0;
    if (!reset) begin
      if (issue_valid0) take_oldest(0);
      if (issue_valid1) take_oldest(1);
      // entries accepted two edges back or earlier sit in the DUT queue now.
      waiting = 0;
      foreach (q_stamp[i]) begin
        if (q_stamp[i] <= cyc - 1) waiting++;
      end
      pair_ok = 1'b0;
      if (waiting >= 2) pair_ok = !pair_blocked(class_of(q_instr[0]), class_of(q_instr[1]));
    end
  end

  a_instr0: assert property (@(posedge clk) disable iff (reset)
    issue_valid0 |-> issue_instr0 == exp_instr0)
    else count_mismatch("order_instr0", $sampled(exp_instr0), $sampled(issue_instr0));
  a_pc0: assert property (@(posedge clk) disable iff (reset)
    issue_valid0 |-> issue_pc0 == exp_pc0)
    else count_mismatch("order_pc0", $sampled(exp_pc0), $sampled(issue_pc0));
  a_instr1: assert property (@(posedge clk) disable iff (reset)
    issue_valid1 |-> issue_instr1 == exp_instr1)
    else count_mismatch("order_instr1", $sampled(exp_instr1), $sampled(issue_instr1));
  a_pc1: assert property (@(posedge clk) disable iff (reset)
    issue_valid1 |-> issue_pc1 == exp_pc1)
    else count_mismatch("order_pc1", $sampled(exp_pc1), $sampled(issue_pc1));
  a_op0: assert property (@(posedge clk) disable iff (reset)
    issue_valid0 |-> issue_op0 == exp_op0)
    else count_mismatch("class_op0", 32'($sampled(exp_op0)), 32'($sampled(issue_op0)));
  a_op1: assert property (@(posedge clk) disable iff (reset)
    issue_valid1 |-> issue_op1 == exp_op1)
    else count_mismatch("class_op1", 32'($sampled(exp_op1)), 32'($sampled(issue_op1)));

  a_pair_order: assert property (@(posedge clk) disable iff (reset)
    issue_valid1 |-> issue_valid0)
    else log_failure("issue_valid1 was high without issue_valid0");
  a_branch_pair: assert property (@(posedge clk) disable iff (reset)
    issue_valid1 |-> !(issue_op0 == op_branch && issue_op1 == op_branch))
    else log_failure("two branches were issued together");
  a_mem_pair: assert property (@(posedge clk) disable iff (reset)
    issue_valid1 |-> !(is_mem(issue_op0) && is_mem(issue_op1)))
    else log_failure("two memory operations were issued together");
  a_no_split: assert property (@(posedge clk) disable iff (reset)
    !issue_stall && pair_ok |=> issue_valid1)
    else log_failure("an allowed pair was split while two entries were waiting");
  a_stall: assert property (@(posedge clk) disable iff (reset)
    issue_stall |=> !issue_valid0 && !issue_valid1)
    else log_failure("an instruction issued during a stall");
  a_reset: assert property (@(posedge clk)
    reset_seen |-> !issue_valid0 && !issue_valid1 && fetch_ready)
    else log_failure("issue valids or fetch_ready wrong during or right after reset");
  a_underrun: assert property (@(posedge clk) disable iff (reset)
    !underrun)
    else log_failure("an instruction issued that was never fetched");
  a_latency: assert property (@(posedge clk) disable iff (reset)
    probe_hit |-> probe_lat == 3)
    else count_mismatch("latency", 32'd3, 32'($sampled(probe_lat)));

  // called at a falling edge; returns at the next one.
  task automatic drive_step(input bit want_push, input bit want_pair, input bit stall,
                            input bit probe);
    logic [INSTR_WIDTH-1:0] w0;
    logic [INSTR_WIDTH-1:0] w1;
    issue_stall = stall;
    if (!fetch_ready) ready_low_seen = 1'b1;
    if (want_push && fetch_ready) begin
      w0 = rand_word();
      w1 = rand_word();
      fetch_valid0 = 1'b1;
      fetch_valid1 = want_pair;
      fetch_pc = next_pc;
      fetch_instr0 = w0;
      fetch_instr1 = w1;
      record_word(w0, next_pc, probe);
      if (want_pair) record_word(w1, next_pc + 4, 1'b0);
      next_pc = next_pc + 8;
    end else begin
      fetch_valid0 = 1'b0;
      fetch_valid1 = 1'b0;
    end
    @(negedge clk);
  endtask

  task automatic wait_drain(input string phase);
    int n;
    n = 0;
    while (q_instr.size() != 0 && n < WAIT_LIMIT) begin
      drive_step(1'b0, 1'b0, 1'b0, 1'b0);
      n++;
    end
    if (q_instr.size() != 0) log_failure({"timeout, words still waiting after ", phase});
  endtask

  initial begin : stimulus
    int stall_left;
    reset = 1'b1;
    fetch_valid0 = 1'b0;
    fetch_valid1 = 1'b0;
    fetch_pc = '0;
    fetch_instr0 = '0;
    fetch_instr1 = '0;
    issue_stall = 1'b0;
    next_pc = 32'h0000_1000;
    ready_low_seen = 1'b0;
    stall_left = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    drive_step(1'b1, 1'b0, 1'b0, 1'b1);
    wait_drain("latency probe");

    // random traffic with short stall bursts.
    for (int i = 0; i < 400; i++) begin
      if (stall_left > 0) begin
        stall_left--;
      end else if (rand_below(10) == 0) begin
        stall_left = 1 + rand_below(6);
      end
      drive_step(rand_below(4) != 0, rand_below(2) == 1, stall_left > 0, 1'b0);
    end
    wait_drain("random traffic");

    // a long stall fills the queue until fetch_ready drops.
    ready_low_seen = 1'b0;
    for (int i = 0; i < 60; i++) drive_step(1'b1, 1'b1, 1'b1, 1'b0);
    a_ready_fell: assert (ready_low_seen)
      else log_failure("fetch_ready never fell during the long stall");
    wait_drain("stall release");

    for (int i = 0; i < 200; i++) drive_step(1'b1, rand_below(4) != 0, 1'b0, 1'b0);
    wait_drain("full rate traffic");

    // the last issued words are compared on the following edges.
    repeat (2) @(negedge clk);

    $display("done: %0d mismatches, %0d other failures, %0d words issued",
             mismatch_count, failure_count, words_issued);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/frontend_pkg.sv
rtl/predecode_stage.sv
rtl/dual_issue_queue.sv
rtl/issue_stage.sv
rtl/frontend_top.sv
sim/tb_clock_gen.sv
sim/tb_frontend.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_frontend
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
